// ==== Makefile ====
sim:
	verilator --binary --timing --assert -f mipsExecUnit.f --top-module tb_mipsExecUnit -o simv
	./obj_dir/simv | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`include "mips_exec_cfg.svh"

module alu (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 reqValid,
    input  mipsExecPkg::execReqT reqData,
    input  logic                 resReady,
    output logic                 reqReady,
    output logic                 resValid,
    output mipsExecPkg::execResT resData
);

    wire mipsExecPkg::execDecT  dec;
    mipsExecPkg::functE         funct;
    mipsExecPkg::aluCtrlE       aluCtrl;
    mipsExecPkg::execResT       resNext;
    mipsExecPkg::execResT       resReg;
    logic [`MIPS_DATA_W-1:0]    opA;
    logic [`MIPS_DATA_W-1:0]    opB;
    logic [`MIPS_SHAMT_W-1:0]   shamt;
    logic [`MIPS_SHAMT_W-1:0]   shVar;
    logic                       resFull;

    mainDecoder mainDecoder_inst (
        .instr   (reqData.instr),
        .aluOp   (dec.aluOp),
        .immExt  (dec.immExt),
        .useImm  (dec.useImm),
        .illegal (dec.illegal)
    );

    assign funct = mipsExecPkg::functE'(reqData.instr[`MIPS_FUNCT_LSB +: `MIPS_OP_W]);

    aluControl aluControl_inst (
        .aluOp   (dec.aluOp),
        .funct   (funct),
        .aluCtrl (aluCtrl)
    );

    assign opA   = reqData.rsVal;
    assign opB   = dec.useImm ? dec.immExt : reqData.rtVal;
    assign shamt = reqData.instr[`MIPS_SHAMT_LSB +: `MIPS_SHAMT_W];
    assign shVar = reqData.rsVal[`MIPS_SHAMT_W-1:0];     // Variable shifts use rs

    always_comb begin
        resNext.branchTaken = 1'b0;
        resNext.illegal     = dec.illegal;
        case (aluCtrl)
            mipsExecPkg::ALU_ADD,
            mipsExecPkg::ALU_ADDU: resNext.result = opA + opB;   // No overflow trap
            mipsExecPkg::ALU_SUB,
            mipsExecPkg::ALU_SUBU: resNext.result = opA - opB;
            mipsExecPkg::ALU_AND:  resNext.result = opA & opB;
            mipsExecPkg::ALU_OR:   resNext.result = opA | opB;
            mipsExecPkg::ALU_XOR:  resNext.result = opA ^ opB;
            mipsExecPkg::ALU_NOR:  resNext.result = ~(opA | opB);
            mipsExecPkg::ALU_SLT:
                resNext.result = {{(`MIPS_DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
            mipsExecPkg::ALU_SLTU:
                resNext.result = {{(`MIPS_DATA_W-1){1'b0}}, opA < opB};
            mipsExecPkg::ALU_SLL:  resNext.result = reqData.rtVal << shamt;
            mipsExecPkg::ALU_SRL:  resNext.result = reqData.rtVal >> shamt;
            mipsExecPkg::ALU_SRA:  resNext.result = $signed(reqData.rtVal) >>> shamt;
            mipsExecPkg::ALU_SLLV: resNext.result = reqData.rtVal << shVar;
            mipsExecPkg::ALU_SRLV: resNext.result = reqData.rtVal >> shVar;
            mipsExecPkg::ALU_SRAV: resNext.result = $signed(reqData.rtVal) >>> shVar;
            mipsExecPkg::ALU_LUI:  resNext.result = dec.immExt << 16;
            mipsExecPkg::ALU_BEQ: begin
                resNext.result      = opA - opB;
                resNext.branchTaken = (opA == opB);
            end
            mipsExecPkg::ALU_BNE: begin
                resNext.result      = opA - opB;
                resNext.branchTaken = (opA != opB);
            end
            mipsExecPkg::ALU_JUMP: resNext.result = reqData.pcPlus4;   // Link value
            default:               resNext.result = opA + opB;
        endcase
        resNext.zero = (resNext.result == '0);
    end

    // Accept when empty or draining this cycle
    assign reqReady = !resFull || resReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resFull <= 1'b0;
        end else if (reqValid && reqReady) begin
            resFull <= 1'b1;
        end else if (resReady) begin
            resFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            resReg <= resNext;
        end
    end

    assign resValid = resFull;
    assign resData  = resReg;

endmodule

// ==== hw/aluControl.sv ====
`timescale 1ns/1ps

module aluControl (
    input  mipsExecPkg::aluOpE   aluOp,
    input  mipsExecPkg::functE   funct,
    output mipsExecPkg::aluCtrlE aluCtrl
);

    always_comb begin
        case (aluOp)
            mipsExecPkg::ALUOP_ZERO: begin
                // R-type operation selected by funct
                case (funct)
                    mipsExecPkg::FN_SLL:  aluCtrl = mipsExecPkg::ALU_SLL;
                    mipsExecPkg::FN_SRL:  aluCtrl = mipsExecPkg::ALU_SRL;
                    mipsExecPkg::FN_SRA:  aluCtrl = mipsExecPkg::ALU_SRA;
                    mipsExecPkg::FN_SLLV: aluCtrl = mipsExecPkg::ALU_SLLV;
                    mipsExecPkg::FN_SRLV: aluCtrl = mipsExecPkg::ALU_SRLV;
                    mipsExecPkg::FN_SRAV: aluCtrl = mipsExecPkg::ALU_SRAV;
                    mipsExecPkg::FN_JR:   aluCtrl = mipsExecPkg::ALU_JUMP;   // Link value only
                    mipsExecPkg::FN_ADD:  aluCtrl = mipsExecPkg::ALU_ADD;
                    mipsExecPkg::FN_ADDU: aluCtrl = mipsExecPkg::ALU_ADDU;
                    mipsExecPkg::FN_SUB:  aluCtrl = mipsExecPkg::ALU_SUB;
                    mipsExecPkg::FN_SUBU: aluCtrl = mipsExecPkg::ALU_SUBU;
                    mipsExecPkg::FN_AND:  aluCtrl = mipsExecPkg::ALU_AND;
                    mipsExecPkg::FN_OR:   aluCtrl = mipsExecPkg::ALU_OR;
                    mipsExecPkg::FN_XOR:  aluCtrl = mipsExecPkg::ALU_XOR;
                    mipsExecPkg::FN_NOR:  aluCtrl = mipsExecPkg::ALU_NOR;
                    mipsExecPkg::FN_SLT:  aluCtrl = mipsExecPkg::ALU_SLT;
                    mipsExecPkg::FN_SLTU: aluCtrl = mipsExecPkg::ALU_SLTU;
                    default:              aluCtrl = mipsExecPkg::ALU_ADD;    // Unknown funct
                endcase
            end

            mipsExecPkg::ALUOP_ADDIU: aluCtrl = mipsExecPkg::ALU_ADDU;
            mipsExecPkg::ALUOP_ADDI:  aluCtrl = mipsExecPkg::ALU_ADD;
            mipsExecPkg::ALUOP_LUI:   aluCtrl = mipsExecPkg::ALU_LUI;
            mipsExecPkg::ALUOP_BEQ:   aluCtrl = mipsExecPkg::ALU_BEQ;
            mipsExecPkg::ALUOP_BNE:   aluCtrl = mipsExecPkg::ALU_BNE;
            mipsExecPkg::ALUOP_JUMP:  aluCtrl = mipsExecPkg::ALU_JUMP;
            mipsExecPkg::ALUOP_ANDI:  aluCtrl = mipsExecPkg::ALU_AND;
            mipsExecPkg::ALUOP_ORI:   aluCtrl = mipsExecPkg::ALU_OR;
            mipsExecPkg::ALUOP_XORI:  aluCtrl = mipsExecPkg::ALU_XOR;
            mipsExecPkg::ALUOP_SLTI:  aluCtrl = mipsExecPkg::ALU_SLT;
            mipsExecPkg::ALUOP_SLTIU: aluCtrl = mipsExecPkg::ALU_SLTU;
            mipsExecPkg::ALUOP_SRL:   aluCtrl = mipsExecPkg::ALU_SRL;
            mipsExecPkg::ALUOP_SRLV:  aluCtrl = mipsExecPkg::ALU_SRLV;
            default:                  aluCtrl = mipsExecPkg::ALU_ADD;
        endcase
    end

endmodule

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps
`include "mips_exec_cfg.svh"

module mainDecoder (
    input  logic [`MIPS_DATA_W-1:0] instr,
    output mipsExecPkg::aluOpE      aluOp,
    output logic [`MIPS_DATA_W-1:0] immExt,
    output logic                    useImm,
    output logic                    illegal
);

    mipsExecPkg::opcodeE    opcode;
    logic [`MIPS_IMM_W-1:0] imm;
    logic                   zeroExt;

    assign opcode = mipsExecPkg::opcodeE'(instr[`MIPS_OPCODE_LSB +: `MIPS_OP_W]);
    assign imm    = instr[`MIPS_IMM_W-1:0];

    assign immExt = zeroExt ? {{(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}, imm}
                            : {{(`MIPS_DATA_W-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};

    always_comb begin
        aluOp   = mipsExecPkg::ALUOP_ZERO;
        useImm  = 1'b0;
        zeroExt = 1'b0;
        illegal = 1'b0;
        case (opcode)
            mipsExecPkg::OP_RTYPE: aluOp = mipsExecPkg::ALUOP_ZERO;
            mipsExecPkg::OP_J,
            mipsExecPkg::OP_JAL:   aluOp = mipsExecPkg::ALUOP_JUMP;
            mipsExecPkg::OP_BEQ:   aluOp = mipsExecPkg::ALUOP_BEQ;    // Compares rs with rt
            mipsExecPkg::OP_BNE:   aluOp = mipsExecPkg::ALUOP_BNE;
            mipsExecPkg::OP_ADDI: begin
                aluOp  = mipsExecPkg::ALUOP_ADDI;
                useImm = 1'b1;
            end
            mipsExecPkg::OP_ADDIU: begin
                aluOp  = mipsExecPkg::ALUOP_ADDIU;
                useImm = 1'b1;
            end
            mipsExecPkg::OP_SLTI: begin
                aluOp  = mipsExecPkg::ALUOP_SLTI;
                useImm = 1'b1;
            end
            mipsExecPkg::OP_SLTIU: begin
                aluOp  = mipsExecPkg::ALUOP_SLTIU;
                useImm = 1'b1;
            end
            mipsExecPkg::OP_ANDI: begin
                aluOp   = mipsExecPkg::ALUOP_ANDI;
                useImm  = 1'b1;
                zeroExt = 1'b1;
            end
            mipsExecPkg::OP_ORI: begin
                aluOp   = mipsExecPkg::ALUOP_ORI;
                useImm  = 1'b1;
                zeroExt = 1'b1;
            end
            mipsExecPkg::OP_XORI: begin
                aluOp   = mipsExecPkg::ALUOP_XORI;
                useImm  = 1'b1;
                zeroExt = 1'b1;
            end
            mipsExecPkg::OP_LUI: begin
                aluOp  = mipsExecPkg::ALUOP_LUI;
                useImm = 1'b1;
            end
            default: illegal = 1'b1;    // Unknown opcode
        endcase
    end

endmodule

// ==== hw/mipsExecPkg.sv ====
`include "mips_exec_cfg.svh"

package mipsExecPkg;

    // Primary opcode field
    typedef enum logic [`MIPS_OP_W-1:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_JAL   = 6'd3,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15
    } opcodeE;

    // R-type function field
    typedef enum logic [`MIPS_OP_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functE;

    // Operation class from the main decoder
    typedef enum logic [`MIPS_OP_W-1:0] {
        ALUOP_ZERO  = 6'd0,     // R-type, decode funct
        ALUOP_ADDIU = 6'd1,
        ALUOP_ADDI  = 6'd2,
        ALUOP_LUI   = 6'd4,
        ALUOP_BEQ   = 6'd6,
        ALUOP_BNE   = 6'd7,
        ALUOP_JUMP  = 6'd11,    // J, JAL
        ALUOP_ANDI  = 6'd12,
        ALUOP_ORI   = 6'd13,
        ALUOP_XORI  = 6'd14,
        ALUOP_SLTI  = 6'd16,
        ALUOP_SLTIU = 6'd17,
        ALUOP_SRL   = 6'd18,    // Not produced by the decoder
        ALUOP_SRLV  = 6'd20     // Not produced by the decoder
    } aluOpE;

    // ALU control codes
    typedef enum logic [`MIPS_OP_W-1:0] {
        ALU_ADD  = 6'd0,
        ALU_ADDU = 6'd1,
        ALU_SUB  = 6'd2,
        ALU_BEQ  = 6'd9,
        ALU_BNE  = 6'd10,
        ALU_JUMP = 6'd14,
        ALU_SRAV = 6'd15,
        ALU_LUI  = 6'd17,
        ALU_AND  = 6'd18,
        ALU_OR   = 6'd19,
        ALU_NOR  = 6'd20,
        ALU_XOR  = 6'd21,
        ALU_SLL  = 6'd23,
        ALU_SRL  = 6'd24,
        ALU_SRA  = 6'd28,
        ALU_SLT  = 6'd30,
        ALU_SLTU = 6'd31,
        ALU_SLLV = 6'd36,
        ALU_SRLV = 6'd37,
        ALU_SUBU = 6'd45
    } aluCtrlE;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] instr;
        logic [`MIPS_DATA_W-1:0] rsVal;
        logic [`MIPS_DATA_W-1:0] rtVal;
        logic [`MIPS_DATA_W-1:0] pcPlus4;
    } execReqT;

    // Main decoder outputs
    typedef struct packed {
        aluOpE                   aluOp;
        logic [`MIPS_DATA_W-1:0] immExt;
        logic                    useImm;
        logic                    illegal;
    } execDecT;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] result;
        logic                    zero;
        logic                    branchTaken;
        logic                    illegal;
    } execResT;

endpackage

// ==== hw/mipsExecUnit.sv ====
`timescale 1ns/1ps

module mipsExecUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inReq,
    input  mipsExecPkg::execReqT inData,
    input  logic                 outAck,
    output logic                 inAck,
    output logic                 outReq,
    output mipsExecPkg::execResT outData
);

    logic                 reqValid;
    logic                 reqReady;
    mipsExecPkg::execReqT reqData;
    logic                 resValid;
    logic                 resReady;
    mipsExecPkg::execResT resData;

    reqAckReceiver reqAckReceiver_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inReq    (inReq),
        .inData   (inData),
        .reqReady (reqReady),
        .inAck    (inAck),
        .reqValid (reqValid),
        .reqData  (reqData)
    );

    alu alu_inst (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqData  (reqData),
        .resReady (resReady),
        .reqReady (reqReady),
        .resValid (resValid),
        .resData  (resData)
    );

    resultSender resultSender_inst (
        .clk      (clk),
        .rstN     (rstN),
        .resValid (resValid),
        .resData  (resData),
        .outAck   (outAck),
        .resReady (resReady),
        .outReq   (outReq),
        .outData  (outData)
    );

endmodule

// ==== hw/reqAckReceiver.sv ====
`timescale 1ns/1ps

module reqAckReceiver (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inReq,
    input  mipsExecPkg::execReqT inData,
    input  logic                 reqReady,
    output logic                 inAck,
    output logic                 reqValid,
    output mipsExecPkg::execReqT reqData
);

    mipsExecPkg::execReqT slot;
    logic                 slotFull;
    logic                 captureEn;

    // New request only once the previous ack has completed
    assign captureEn = inReq && !slotFull && !inAck;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inAck    <= 1'b0;
            slotFull <= 1'b0;
        end else begin
            if (captureEn) begin
                inAck <= 1'b1;
            end else if (!inReq) begin
                inAck <= 1'b0;          // Return to zero phase
            end

            if (captureEn) begin
                slotFull <= 1'b1;
            end else if (reqValid && reqReady) begin
                slotFull <= 1'b0;       // Handed to processing stage
            end
        end
    end

    always_ff @(posedge clk) begin
        if (captureEn) begin
            slot <= inData;
        end
    end

    assign reqValid = slotFull;
    assign reqData  = slot;

endmodule

// ==== hw/resultSender.sv ====
`timescale 1ns/1ps

module resultSender (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 resValid,
    input  mipsExecPkg::execResT resData,
    input  logic                 outAck,
    output logic                 resReady,
    output logic                 outReq,
    output mipsExecPkg::execResT outData
);

    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_REQ,
        SEND_REL
    } sendStateE;

    sendStateE            state;
    mipsExecPkg::execResT slot;
    logic                 slotFull;

    assign resReady = !slotFull;
    assign outReq   = (state == SEND_REQ);
    assign outData  = slot;     // Held until the cycle completes

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= SEND_IDLE;
            slotFull <= 1'b0;
        end else begin
            if (resValid && resReady) begin
                slotFull <= 1'b1;
            end
            case (state)
                SEND_IDLE: begin
                    if (slotFull && !outAck) begin
                        state <= SEND_REQ;
                    end
                end
                SEND_REQ: begin
                    if (outAck) begin
                        state <= SEND_REL;      // Consumer took the data
                    end
                end
                SEND_REL: begin
                    if (!outAck) begin
                        state    <= SEND_IDLE;
                        slotFull <= 1'b0;
                    end
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resValid && resReady) begin
            slot <= resData;
        end
    end

endmodule

// ==== mipsExecUnit.f ====
+incdir+.
hw/mipsExecPkg.sv
hw/reqAckReceiver.sv
hw/mainDecoder.sv
hw/aluControl.sv
hw/alu.sv
hw/resultSender.sv
hw/mipsExecUnit.sv
tb/mipsExecUnit_checker.sv
tb/tb_mipsExecUnit.sv

// ==== mips_exec_cfg.svh ====
`ifndef MIPS_EXEC_CFG_SVH
`define MIPS_EXEC_CFG_SVH

// Datapath width of operands and results
`define MIPS_DATA_W 32

// Opcode, funct and ALU control codes share one width
`define MIPS_OP_W 6

`define MIPS_SHAMT_W 5     // Shift amount field
`define MIPS_IMM_W 16      // Immediate field

// Field positions in the instruction word
`define MIPS_OPCODE_LSB 26
`define MIPS_SHAMT_LSB 6
`define MIPS_FUNCT_LSB 0

`endif

// ==== tb/mipsExecUnit_checker.sv ====
`timescale 1ns/1ps

module mipsExecUnit_checker (
    input logic                 clk,
    input logic                 rstN,
    input logic                 inReq,
    input logic                 inAck,
    input logic                 outReq,
    input logic                 outAck,
    input mipsExecPkg::execResT outData
);

    // Ack answers a pending request only
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inAck) |-> $past(inReq))
        else $error("inAck rose while inReq was low");

    outDataStable: assert property (@(posedge clk) disable iff (!rstN)
        ((outReq || outAck) && $past(outReq || outAck)) |-> $stable(outData))
        else $error("outData changed during an output handshake");

    // Next request waits for the return to zero
    reqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outReq) |-> !$past(outAck))
        else $error("outReq rose while outAck was high");

    resetIdle: assert property (@(posedge clk)
        !rstN |-> (!inAck && !outReq))
        else $error("Handshake outputs not low during reset");

endmodule

bind mipsExecUnit mipsExecUnit_checker mipsExecUnit_checker_inst (
    .clk     (clk),
    .rstN    (rstN),
    .inReq   (inReq),
    .inAck   (inAck),
    .outReq  (outReq),
    .outAck  (outAck),
    .outData (outData)
);

// ==== tb/tb_mipsExecUnit.sv ====
`timescale 1ns/1ps

module tb_mipsExecUnit;

    localparam int numRType       = 17;
    localparam int numImm         = 16;
    localparam int numBranch      = 7;
    localparam int numIllegal     = 4;
    localparam int numBurst       = 8;
    localparam int numReqs        = numRType + numImm + numBranch + numIllegal + numBurst;
    localparam int watchdogCycles = numReqs * 40 + 100;    // Reset plus margin

    logic                 clk;
    logic                 rstN;
    logic                 inReq;
    mipsExecPkg::execReqT inData;
    logic                 outAck;
    logic                 inAck;
    logic                 outReq;
    mipsExecPkg::execResT outData;

    mipsExecUnit mipsExecUnit_inst (
        .clk     (clk),
        .rstN    (rstN),
        .inReq   (inReq),
        .inData  (inData),
        .outAck  (outAck),
        .inAck   (inAck),
        .outReq  (outReq),
        .outData (outData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(watchdogCycles * 20);
        $display("Watchdog expired, the DUT stopped completing requests");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

    // R-type result from the funct field, standard MIPS codes
    function automatic logic [31:0] rTypeResult(input mipsExecPkg::execReqT req);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sa;
        a  = req.rsVal;
        b  = req.rtVal;
        sa = req.instr[10:6];
        case (req.instr[5:0])
            6'h00:        return b << sa;
            6'h02:        return b >> sa;
            6'h03:        return $signed(b) >>> sa;
            6'h04:        return b << a[4:0];
            6'h06:        return b >> a[4:0];
            6'h07:        return $signed(b) >>> a[4:0];
            6'h08:        return req.pcPlus4;        // JR link value
            6'h22, 6'h23: return a - b;
            6'h24:        return a & b;
            6'h25:        return a | b;
            6'h26:        return a ^ b;
            6'h27:        return ~(a | b);
            6'h2A:        return {31'd0, $signed(a) < $signed(b)};
            6'h2B:        return {31'd0, a < b};
            default:      return a + b;              // ADD, ADDU and unknown funct
        endcase
    endfunction

    function automatic mipsExecPkg::execResT expectedResult(input mipsExecPkg::execReqT req);
        logic [31:0]          a;
        logic [31:0]          sImm;
        logic [31:0]          zImm;
        mipsExecPkg::execResT e;
        a    = req.rsVal;
        sImm = {{16{req.instr[15]}}, req.instr[15:0]};
        zImm = {16'h0000, req.instr[15:0]};
        e    = '0;
        case (req.instr[31:26])
            6'd0:       e.result = rTypeResult(req);
            6'd2, 6'd3: e.result = req.pcPlus4;
            6'd4: begin
                e.result      = a - req.rtVal;
                e.branchTaken = (a == req.rtVal);
            end
            6'd5: begin
                e.result      = a - req.rtVal;
                e.branchTaken = (a != req.rtVal);
            end
            6'd8, 6'd9: e.result = a + sImm;
            6'd10:      e.result = {31'd0, $signed(a) < $signed(sImm)};
            6'd11:      e.result = {31'd0, a < sImm};
            6'd12:      e.result = a & zImm;
            6'd13:      e.result = a | zImm;
            6'd14:      e.result = a ^ zImm;
            6'd15:      e.result = {req.instr[15:0], 16'h0000};
            default: begin
                e.result  = rTypeResult(req);    // Unknown opcode uses the R-type class
                e.illegal = 1'b1;
            end
        endcase
        e.zero = (e.result == 32'd0);
        return e;
    endfunction

    function automatic mipsExecPkg::execReqT makeReq(input logic [31:0] instr);
        mipsExecPkg::execReqT req;
        req.instr   = instr;
        req.rsVal   = $urandom;
        req.rtVal   = $urandom;
        req.pcPlus4 = $urandom & 32'hFFFF_FFFC;
        return req;
    endfunction

    task automatic checkEqual(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", testName, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic sendRequest(input mipsExecPkg::execReqT req);
        @(negedge clk);
        inData = req;
        inReq  = 1'b1;
        do @(negedge clk); while (!inAck);
        inReq = 1'b0;
        do @(negedge clk); while (inAck);     // Ack back to zero
    endtask

    task automatic receiveResult(input int ackDelay, output mipsExecPkg::execResT res);
        @(negedge clk);
        while (!outReq) @(negedge clk);
        repeat (ackDelay) @(negedge clk);
        res    = outData;
        outAck = 1'b1;
        do @(negedge clk); while (outReq);
        outAck = 1'b0;
    endtask

    task automatic runSingle(input string testName, input mipsExecPkg::execReqT req);
        mipsExecPkg::execResT got;
        fork
            sendRequest(req);
            receiveResult(0, got);
        join
        checkEqual(testName, 64'(expectedResult(req)), 64'(got));
    endtask

    task automatic testRType();
        logic [5:0]           fnList [16];
        mipsExecPkg::execReqT req;
        fnList = '{mipsExecPkg::FN_SLL, mipsExecPkg::FN_SRL, mipsExecPkg::FN_SRA,
                   mipsExecPkg::FN_SLLV, mipsExecPkg::FN_SRLV, mipsExecPkg::FN_SRAV,
                   mipsExecPkg::FN_ADD, mipsExecPkg::FN_ADDU, mipsExecPkg::FN_SUB,
                   mipsExecPkg::FN_SUBU, mipsExecPkg::FN_AND, mipsExecPkg::FN_OR,
                   mipsExecPkg::FN_XOR, mipsExecPkg::FN_NOR, mipsExecPkg::FN_SLT,
                   mipsExecPkg::FN_SLTU};
        for (int i = 0; i < 16; i++) begin
            runSingle("testRType", makeReq({6'd0, 15'h0, 5'($urandom), fnList[i]}));
        end
        req       = makeReq({6'd0, 15'h0, 5'd0, 6'h22});
        req.rtVal = req.rsVal;                 // SUB to zero
        runSingle("testRType", req);
    endtask

    task automatic testImmediate();
        logic [5:0]  opList [8];
        logic [15:0] immList [2];
        opList  = '{mipsExecPkg::OP_ADDI, mipsExecPkg::OP_ADDIU, mipsExecPkg::OP_ANDI,
                    mipsExecPkg::OP_ORI, mipsExecPkg::OP_XORI, mipsExecPkg::OP_SLTI,
                    mipsExecPkg::OP_SLTIU, mipsExecPkg::OP_LUI};
        immList = '{16'h8001, 16'h1234};    // Negative, positive
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 2; j++) begin
                runSingle("testImmediate", makeReq({opList[i], 10'h0, immList[j]}));
            end
        end
    endtask

    task automatic testBranchJump();
        mipsExecPkg::execReqT req;
        req       = makeReq({mipsExecPkg::OP_BEQ, 10'h0, 16'h0010});
        req.rtVal = req.rsVal;
        runSingle("testBranchJump", req);
        runSingle("testBranchJump", makeReq({mipsExecPkg::OP_BEQ, 10'h0, 16'h0010}));
        req       = makeReq({mipsExecPkg::OP_BNE, 10'h0, 16'hFFF0});
        req.rtVal = req.rsVal;
        runSingle("testBranchJump", req);
        runSingle("testBranchJump", makeReq({mipsExecPkg::OP_BNE, 10'h0, 16'hFFF0}));
        runSingle("testBranchJump", makeReq({mipsExecPkg::OP_J, 26'($urandom)}));
        runSingle("testBranchJump", makeReq({mipsExecPkg::OP_JAL, 26'($urandom)}));
        runSingle("testBranchJump", makeReq({6'd0, 20'h0, mipsExecPkg::FN_JR}));
    endtask

    task automatic testIllegal();
        runSingle("testIllegal", makeReq({6'h01, 26'($urandom)}));
        runSingle("testIllegal", makeReq({6'h23, 26'($urandom)}));
        runSingle("testIllegal", makeReq({6'h3F, 26'($urandom)}));
        runSingle("testIllegal", makeReq({6'd0, 20'h0, 6'h3C}));    // Unknown funct
    endtask

    task automatic testBackPressure();
        mipsExecPkg::execReqT reqs [numBurst];
        mipsExecPkg::execResT got;
        for (int i = 0; i < numBurst; i++) begin
            reqs[i] = (i % 2 == 0) ? makeReq({6'd0, 20'h0, mipsExecPkg::FN_ADDU})
                                   : makeReq({mipsExecPkg::OP_ADDIU, 10'h0, 16'($urandom)});
        end
        fork
            for (int i = 0; i < numBurst; i++) begin
                sendRequest(reqs[i]);
            end
            for (int k = 0; k < numBurst; k++) begin
                receiveResult($urandom_range(10, 0), got);
                checkEqual("testBackPressure", 64'(expectedResult(reqs[k])), 64'(got));
            end
        join
    endtask

    initial begin
        rstN   = 1'b0;
        inReq  = 1'b0;
        inData = '0;
        outAck = 1'b0;
        void'($urandom(92466));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        testRType();
        testImmediate();
        testBranchJump();
        testIllegal();
        testBackPressure();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
